/* src/dram_cfg_pkg.sv */
// DRAM front end configuration
// field widths, queue depths and bank count
`default_nettype none

package dram_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // address and data widths
    //////////////////////////////////////////////////////////////////////
    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;
    localparam int BANK_BITS = 2;
    // row, col and bank concatenated
    localparam int ADDR_BITS = ROW_BITS + COL_BITS + BANK_BITS;
    localparam int N_BANKS   = 4;
    localparam int DATA_BITS = 32;

    //////////////////////////////////////////////////////////////////////
    // queue depths, all powers of two
    //////////////////////////////////////////////////////////////////////
    localparam int RQ_DEPTH = 4;
    localparam int WQ_DEPTH = 4;
    localparam int SQ_DEPTH = 2;
    // outstanding reads awaiting return
    localparam int RO_DEPTH = 8;

endpackage

`default_nettype wire

/* src/dram_cmd_pkg.sv */
// DRAM front end command types
// operation, address, data word and queued request
`default_nettype none

package dram_cmd_pkg;

    import dram_cfg_pkg::*;

    // one bit operation code
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

    // bank index, selects one bank controller
    typedef logic [BANK_BITS-1:0] bank_t;

    // bank sits in the low bits
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        bank_t               bank;
    } addr_t;

    typedef logic [DATA_BITS-1:0] data_t;

    // wdata is don't care for reads
    typedef struct packed {
        op_t   op;
        addr_t addr;
        data_t wdata;
    } req_t;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
// synchronous FIFO, head visible while not empty
// depth and payload type chosen per instance
`default_nettype none

module sync_fifo #(
    // power of two
    parameter int  DEPTH = 4,
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire logic     i_push,
    input  wire payload_t i_data,
    input  wire logic     i_pop,
    output payload_t      o_data,
    output logic          o_empty,
    output logic          o_full
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    // one extra bit to hold DEPTH itself
    logic [$clog2(DEPTH):0]     count;

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap on their own
            if (i_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, write slot may equal head when full and popping
    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH[$clog2(DEPTH):0]);

    // full accepts a push only alongside a pop
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push && o_full |-> i_pop);
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> !o_empty);

endmodule

`default_nettype wire

/* src/write_queue.sv */
// write request queue with an address CAM over every entry
// raises the flush flag on a read-after-write hit or when full
`default_nettype none

module write_queue
    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire logic  i_push,
    input  wire req_t  i_req,
    input  wire logic  i_pop,
    input  wire logic  i_rd_accept,
    input  wire addr_t i_rd_addr,
    output req_t       o_head,
    output logic       o_empty,
    output logic       o_full,
    output logic       o_flush
);

    // per entry valid bits seen in parallel
    logic [WQ_DEPTH-1:0]            valid_q;
    logic [WQ_DEPTH-1:0]            valid_nxt;
    // address tags for the compare with data kept beside them
    logic [ADDR_BITS-1:0]           tag_q [WQ_DEPTH];
    data_t                          wdata_q [WQ_DEPTH];
    logic [$clog2(WQ_DEPTH)-1:0]    head_q;
    logic [$clog2(WQ_DEPTH)-1:0]    tail_q;
    logic [WQ_DEPTH-1:0]            hit;
    logic                           raw_hit;
    logic                           flush_q;

    //////////////////////////////////////////////////////////////////////
    // read-after-write compare
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        for (int i = 0; i < WQ_DEPTH; i++)
        begin
            hit[i] = valid_q[i] && (tag_q[i] == i_rd_addr);
        end
    end

    // only an accepted read counts
    assign raw_hit = i_rd_accept && (|hit);

    // occupancy after this edge
    always_comb
    begin
        valid_nxt = valid_q;
        if (i_pop)
        begin
            valid_nxt[head_q] = 1'b0;
        end
        if (i_push)
        begin
            valid_nxt[tail_q] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            flush_q <= 1'b0;
        end
        else
        begin
            valid_q <= valid_nxt;
            if (i_pop)
            begin
                head_q <= head_q + 1'b1;
            end
            if (i_push)
            begin
                tail_q <= tail_q + 1'b1;
            end
            // drain wins since a hit on the last entry leaving needs no flush
            if (~|valid_nxt)
            begin
                flush_q <= 1'b0;
            end
            else if (raw_hit || (&valid_nxt))
            begin
                flush_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            tag_q[tail_q]   <= i_req.addr;
            wdata_q[tail_q] <= i_req.wdata;
        end
    end

    // rebuild the request as a write
    always_comb
    begin
        o_head.op    = OP_WRITE;
        o_head.addr  = tag_q[head_q];
        o_head.wdata = wdata_q[head_q];
    end

    assign o_empty = ~|valid_q;
    assign o_full  = &valid_q;
    assign o_flush = flush_q;

    a_flush_not_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_flush |-> !o_empty);

endmodule

`default_nettype wire

/* src/request_scheduler.sv */
// host request intake, read and write queues, read-first arbiter
// winner moves into the scheduled queue, one per cycle
`default_nettype none

module request_scheduler
    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire logic  i_req_valid,
    input  wire op_t   i_req_op,
    input  wire addr_t i_req_addr,
    input  wire data_t i_req_wdata,
    input  wire logic  i_sched_pop,
    output logic       o_req_ready,
    output req_t       o_sched_head,
    output logic       o_sched_empty
);

    logic   accept;
    req_t   new_req;
    logic   rq_push;
    logic   rq_pop;
    req_t   rq_head;
    logic   rq_empty;
    logic   rq_full;
    logic   wq_push;
    logic   wq_pop;
    req_t   wq_head;
    logic   wq_empty;
    logic   wq_full;
    logic   flush;
    logic   sq_push;
    req_t   sq_in;
    logic   sq_full;
    logic   sq_room;

    //////////////////////////////////////////////////////////////////////
    // host handshake and steering
    //////////////////////////////////////////////////////////////////////
    // stall while flushing so nothing new lands behind the writes
    assign o_req_ready = !rq_full && !wq_full && !flush;
    assign accept      = i_req_valid && o_req_ready;
    assign new_req     = '{op: i_req_op, addr: i_req_addr, wdata: i_req_wdata};
    assign rq_push     = accept && (i_req_op == OP_READ);
    assign wq_push     = accept && (i_req_op == OP_WRITE);

    sync_fifo #(.DEPTH(RQ_DEPTH), .payload_t(req_t)) u_read_queue (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rq_push),
        .i_data  (new_req),
        .i_pop   (rq_pop),
        .o_data  (rq_head),
        .o_empty (rq_empty),
        .o_full  (rq_full)
    );

    write_queue u_write_queue (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (wq_push),
        .i_req       (new_req),
        .i_pop       (wq_pop),
        .i_rd_accept (rq_push),
        .i_rd_addr   (i_req_addr),
        .o_head      (wq_head),
        .o_empty     (wq_empty),
        .o_full      (wq_full),
        .o_flush     (flush)
    );

    //////////////////////////////////////////////////////////////////////
    // arbiter
    //////////////////////////////////////////////////////////////////////
    // room now, or the head leaves this cycle
    assign sq_room = !sq_full || i_sched_pop;
    // flush implies a queued write, so the two picks never overlap
    assign rq_pop  = sq_room && !rq_empty && !flush;
    assign wq_pop  = sq_room && !wq_empty && (flush || rq_empty);
    assign sq_push = rq_pop || wq_pop;
    assign sq_in   = wq_pop ? wq_head : rq_head;

    sync_fifo #(.DEPTH(SQ_DEPTH), .payload_t(req_t)) u_sched_queue (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (sq_push),
        .i_data  (sq_in),
        .i_pop   (i_sched_pop),
        .o_data  (o_sched_head),
        .o_empty (o_sched_empty),
        .o_full  (sq_full)
    );

endmodule

`default_nettype wire

/* src/bank_dispatch.sv */
// issues the scheduled head to its bank, tracks read order
// and returns read data to the host through one register stage
`default_nettype none

module bank_dispatch
    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;
(
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire req_t                i_sched_head,
    input  wire logic                i_sched_empty,
    input  wire logic [N_BANKS-1:0]  i_bank_ready,
    input  wire logic [N_BANKS-1:0]  i_bank_rvalid,
    input  wire data_t [N_BANKS-1:0] i_bank_rdata,
    output logic                     o_sched_pop,
    output req_t                     o_bank_cmd,
    output logic [N_BANKS-1:0]       o_bank_cmd_valid,
    output logic [N_BANKS-1:0]       o_bank_ren,
    output logic                     o_read_valid,
    output data_t                    o_read_data
);

    bank_t               head_bank;
    logic                head_is_read;
    logic                ro_block;
    logic                ro_push;
    logic                ro_pop;
    bank_t               ro_head;
    logic                ro_empty;
    logic                ro_full;
    logic [N_BANKS-1:0]  ret_hs;

    //////////////////////////////////////////////////////////////////////
    // command issue
    //////////////////////////////////////////////////////////////////////
    assign head_bank    = i_sched_head.addr.bank;
    assign head_is_read = (i_sched_head.op == OP_READ);
    // no slot left to remember the return order
    assign ro_block     = head_is_read && ro_full;

    // valid follows ready in the same cycle, head blocks everything behind
    always_comb
    begin
        for (int b = 0; b < N_BANKS; b++)
        begin
            o_bank_cmd_valid[b] = !i_sched_empty && !ro_block && i_bank_ready[b]
                                  && (head_bank == bank_t'(b));
        end
    end

    // one shared command bus, valid picks the bank
    assign o_bank_cmd  = i_sched_head;
    assign o_sched_pop = |(o_bank_cmd_valid & i_bank_ready);
    assign ro_push     = o_sched_pop && head_is_read;

    //////////////////////////////////////////////////////////////////////
    // read return ordering
    //////////////////////////////////////////////////////////////////////
    sync_fifo #(.DEPTH(RO_DEPTH), .payload_t(bank_t)) u_read_order (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (ro_push),
        .i_data  (head_bank),
        .i_pop   (ro_pop),
        .o_data  (ro_head),
        .o_empty (ro_empty),
        .o_full  (ro_full)
    );

    // only the oldest outstanding read may return
    always_comb
    begin
        for (int b = 0; b < N_BANKS; b++)
        begin
            o_bank_ren[b] = !ro_empty && (ro_head == bank_t'(b));
        end
    end

    assign ret_hs = i_bank_rvalid & o_bank_ren;
    assign ro_pop = |ret_hs;

    // host side, one cycle after the return handshake
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_read_valid <= 1'b0;
            o_read_data  <= '0;
        end
        else
        begin
            o_read_valid <= ro_pop;
            if (ro_pop)
            begin
                o_read_data <= i_bank_rdata[ro_head];
            end
        end
    end

    a_cmd_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_bank_cmd_valid));
    a_ren_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_bank_ren));

endmodule

`default_nettype wire

/* src/global_controller.sv */
// DRAM global front end, four banks
// request scheduling feeding per-bank dispatch and read return
`default_nettype none

module global_controller
    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;
(
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    // host request channel
    input  wire logic                i_req_valid,
    input  wire op_t                 i_req_op,
    input  wire addr_t               i_req_addr,
    input  wire data_t               i_req_wdata,
    output logic                     o_req_ready,
    // host read data, no back-pressure
    output logic                     o_read_valid,
    output data_t                    o_read_data,
    // bank command channel
    input  wire logic [N_BANKS-1:0]  i_bank_ready,
    output logic [N_BANKS-1:0]       o_bank_cmd_valid,
    output req_t                     o_bank_cmd,
    // bank read return channel
    input  wire logic [N_BANKS-1:0]  i_bank_rvalid,
    input  wire data_t [N_BANKS-1:0] i_bank_rdata,
    output logic [N_BANKS-1:0]       o_bank_ren
);

    // scheduled queue head handed to dispatch
    req_t   sched_head;
    logic   sched_empty;
    logic   sched_pop;

    request_scheduler u_scheduler (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .i_req_op      (i_req_op),
        .i_req_addr    (i_req_addr),
        .i_req_wdata   (i_req_wdata),
        .i_sched_pop   (sched_pop),
        .o_req_ready   (o_req_ready),
        .o_sched_head  (sched_head),
        .o_sched_empty (sched_empty)
    );

    bank_dispatch u_dispatch (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_sched_head     (sched_head),
        .i_sched_empty    (sched_empty),
        .i_bank_ready     (i_bank_ready),
        .i_bank_rvalid    (i_bank_rvalid),
        .i_bank_rdata     (i_bank_rdata),
        .o_sched_pop      (sched_pop),
        .o_bank_cmd       (o_bank_cmd),
        .o_bank_cmd_valid (o_bank_cmd_valid),
        .o_bank_ren       (o_bank_ren),
        .o_read_valid     (o_read_valid),
        .o_read_data      (o_read_data)
    );

endmodule

`default_nettype wire

/* tests/tb_global_controller.sv */
// testbench for the DRAM global front end
// random bank timing and a scoreboard checked by concurrent assertions
`default_nettype none

module tb_global_controller
    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;
();

    // roughly eight times the length of all five tests
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int N_TESTS        = 5;

    logic                   clk;
    logic                   rst_n;
    logic                   rst_d = 1'b0;
    // host side
    logic                   req_valid;
    op_t                    req_op;
    addr_t                  req_addr;
    data_t                  req_wdata;
    logic                   req_ready;
    logic                   read_valid;
    data_t                  read_data;
    // bank side
    logic [N_BANKS-1:0]     bank_ready = '0;
    logic [N_BANKS-1:0]     bank_rvalid = '0;
    data_t [N_BANKS-1:0]    bank_rdata = '0;
    logic [N_BANKS-1:0]     cmd_valid;
    req_t                   cmd;
    logic [N_BANKS-1:0]     ren;
    logic                   hold_banks;

    // sparse bank memories plus pending read words
    data_t  bank_mem [N_BANKS][logic [ADDR_BITS-1:0]];
    data_t  ret_q [N_BANKS][$];
    int     ret_delay [N_BANKS] = '{default: 0};

    // scoreboard
    data_t  ref_mem [logic [ADDR_BITS-1:0]];
    req_t   wr_q [$];
    req_t   rd_q [$];
    data_t  exp_q [$];
    int     wr_count = 0;
    int     rd_count = 0;
    int     exp_count = 0;
    req_t   wr_head = '0;
    req_t   rd_head = '0;
    data_t  exp_head = '0;
    int     errors = 0;
    int     tests_failed = 0;
    int     cycle_count = 0;

    global_controller dut_i (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_req_valid      (req_valid),
        .i_req_op         (req_op),
        .i_req_addr       (req_addr),
        .i_req_wdata      (req_wdata),
        .o_req_ready      (req_ready),
        .o_read_valid     (read_valid),
        .o_read_data      (read_data),
        .i_bank_ready     (bank_ready),
        .o_bank_cmd_valid (cmd_valid),
        .o_bank_cmd       (cmd),
        .i_bank_rvalid    (bank_rvalid),
        .i_bank_rdata     (bank_rdata),
        .o_bank_ren       (ren)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        rst_d <= rst_n;
    end

    // odd multiplier so every address bit reaches the word
    function automatic data_t fill_pattern(input addr_t a);
        return (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic addr_t rand_addr();
        logic [ADDR_BITS-1:0] r;
        r = ADDR_BITS'($urandom);
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // behavioral banks
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        for (int b = 0; b < N_BANKS; b++)
        begin
            // command transfer
            if (cmd_valid[b] && bank_ready[b])
            begin
                if (cmd.op == OP_WRITE)
                begin
                    bank_mem[b][cmd.addr] = cmd.wdata;
                end
                else if (bank_mem[b].exists(cmd.addr))
                begin
                    ret_q[b].push_back(bank_mem[b][cmd.addr]);
                end
                else
                begin
                    ret_q[b].push_back(fill_pattern(cmd.addr));
                end
            end
            // oldest word returns first after a random gap
            if (bank_rvalid[b] && ren[b])
            begin
                void'(ret_q[b].pop_front());
                bank_rvalid[b] <= 1'b0;
                ret_delay[b] = $urandom % 5;
            end
            else if (!bank_rvalid[b] && ret_q[b].size() != 0)
            begin
                if (ret_delay[b] == 0)
                begin
                    bank_rvalid[b] <= 1'b1;
                    bank_rdata[b]  <= ret_q[b][0];
                end
                else
                begin
                    ret_delay[b]--;
                end
            end
            // ready three cycles in four unless stalled
            bank_ready[b] <= hold_banks ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // scoreboard updated on the edge that completes each transfer
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        req_t acc;
        if (rst_n)
        begin
            if (req_valid && req_ready)
            begin
                acc.op    = req_op;
                acc.addr  = req_addr;
                acc.wdata = req_wdata;
                if (req_op == OP_WRITE)
                begin
                    ref_mem[req_addr] = req_wdata;
                    wr_q.push_back(acc);
                end
                else
                begin
                    rd_q.push_back(acc);
                    if (ref_mem.exists(req_addr))
                        exp_q.push_back(ref_mem[req_addr]);
                    else
                        exp_q.push_back(fill_pattern(req_addr));
                end
            end
            // writes and reads each stay in their own order
            if (|(cmd_valid & bank_ready))
            begin
                if (cmd.op == OP_WRITE && wr_q.size() != 0)
                    void'(wr_q.pop_front());
                else if (cmd.op == OP_READ && rd_q.size() != 0)
                    void'(rd_q.pop_front());
            end
            if (read_valid && exp_q.size() != 0)
            begin
                void'(exp_q.pop_front());
            end
        end
        wr_count  = wr_q.size();
        rd_count  = rd_q.size();
        exp_count = exp_q.size();
        if (wr_count != 0)
            wr_head = wr_q[0];
        if (rd_count != 0)
            rd_head = rd_q[0];
        if (exp_count != 0)
            exp_head = exp_q[0];
    end

    //////////////////////////////////////////////////////////////////////
    // checks sampled mid-cycle
    //////////////////////////////////////////////////////////////////////
    a_reset_outputs: assert property (@(negedge clk)
        (rst_n && !rst_d) |-> (cmd_valid == '0 && ren == '0 && !read_valid
                               && read_data == '0))
    else
    begin
        errors++;
        $write("CHECK FAILED after reset o_bank_cmd_valid %h o_bank_ren %h",
               cmd_valid, ren);
        $display(" o_read_valid %h o_read_data %h", read_valid, read_data);
    end

    a_reset_ready: assert property (@(negedge clk)
        (rst_n && !rst_d) |-> req_ready)
    else
    begin
        errors++;
        $display("CHECK FAILED o_req_ready got %h expected 1", req_ready);
    end

    // only the bank named by the address
    a_cmd_bank: assert property (@(negedge clk) disable iff (!rst_n)
        (|cmd_valid) |-> cmd_valid == ({{(N_BANKS-1){1'b0}}, 1'b1} << cmd.addr.bank))
    else
    begin
        errors++;
        $display("CHECK FAILED o_bank_cmd_valid got %h for bank %h",
                 cmd_valid, cmd.addr.bank);
    end

    a_cmd_ready: assert property (@(negedge clk) disable iff (!rst_n)
        (cmd_valid & ~bank_ready) == '0)
    else
    begin
        errors++;
        $display("CHECK FAILED o_bank_cmd_valid %h while i_bank_ready %h",
                 cmd_valid, bank_ready);
    end

    a_write_cmd: assert property (@(negedge clk) disable iff (!rst_n)
        ((|cmd_valid) && cmd.op == OP_WRITE) |-> (wr_count != 0
            && cmd.addr == wr_head.addr && cmd.wdata == wr_head.wdata))
    else
    begin
        errors++;
        $display("CHECK FAILED o_bank_cmd got %h expected %h", cmd, wr_head);
    end

    // wdata carries nothing for a read
    a_read_cmd: assert property (@(negedge clk) disable iff (!rst_n)
        ((|cmd_valid) && cmd.op == OP_READ) |-> (rd_count != 0 && cmd.addr == rd_head.addr))
    else
    begin
        errors++;
        $display("CHECK FAILED o_bank_cmd.addr got %h expected %h", cmd.addr, rd_head.addr);
    end

    a_read_data: assert property (@(negedge clk) disable iff (!rst_n)
        read_valid |-> (exp_count != 0 && read_data == exp_head))
    else
    begin
        errors++;
        $display("CHECK FAILED o_read_data got %h expected %h", read_data, exp_head);
    end

    //////////////////////////////////////////////////////////////////////
    // host driver
    //////////////////////////////////////////////////////////////////////
    // called on a rising edge
    task automatic drive_req(input op_t op, input addr_t addr, input data_t wdata);
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= wdata;
    endtask

    task automatic send_req(input op_t op, input addr_t addr, input data_t wdata);
        drive_req(op, addr, wdata);
        do
            @(posedge clk);
        while (!req_ready);
        req_valid <= 1'b0;
    endtask

    // every accepted request issued and every read returned
    task automatic wait_drained();
        @(negedge clk);
        while (wr_count != 0 || rd_count != 0 || exp_count != 0)
        begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before)
        begin
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        int     errs_before;
        addr_t  a;
        data_t  d;
        logic   stall_seen;
        void'($urandom(32'h02aa_b60e));
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_op     = OP_READ;
        req_addr   = '0;
        req_wdata  = '0;
        hold_banks = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // test 1 checks the idle outputs right after release
        errs_before = errors;
        repeat (2) @(posedge clk);
        report_test(1, "reset values", errs_before);

        // test 2 writes then reads back one address
        errs_before = errors;
        a = rand_addr();
        d = $urandom;
        send_req(OP_WRITE, a, d);
        wait_drained();
        send_req(OP_READ, a, '0);
        wait_drained();
        report_test(2, "single bank routing", errs_before);

        // test 3 reads over every bank with returns in accept order
        errs_before = errors;
        for (int i = 0; i < 24; i++)
        begin
            a = rand_addr();
            a.bank = i[BANK_BITS-1:0];
            send_req(OP_READ, a, '0);
        end
        wait_drained();
        report_test(3, "read ordering", errs_before);

        // test 4 holds the scheduled queue full so the write stays queued
        errs_before = errors;
        hold_banks <= 1'b1;
        repeat (2) @(posedge clk);
        send_req(OP_WRITE, rand_addr(), $urandom);
        send_req(OP_WRITE, rand_addr(), $urandom);
        a = rand_addr();
        send_req(OP_WRITE, a, $urandom);
        send_req(OP_READ, a, '0);
        hold_banks <= 1'b0;
        wait_drained();
        report_test(4, "read after write", errs_before);

        // test 5 stalls all banks until the host sees back-pressure
        errs_before = errors;
        hold_banks <= 1'b1;
        repeat (2) @(posedge clk);
        stall_seen = 1'b0;
        drive_req(($urandom % 2 != 0) ? OP_WRITE : OP_READ, rand_addr(), $urandom);
        for (int i = 0; i < 64 && !stall_seen; i++)
        begin
            @(posedge clk);
            if (!req_ready)
                stall_seen = 1'b1;
            else
                drive_req(($urandom % 2 != 0) ? OP_WRITE : OP_READ, rand_addr(), $urandom);
        end
        if (!stall_seen)
        begin
            errors++;
            $display("o_req_ready stayed high while every bank was stalled");
        end
        hold_banks <= 1'b0;
        // pending request still waits for its accept
        do
            @(posedge clk);
        while (!req_ready);
        req_valid <= 1'b0;
        wait_drained();
        report_test(5, "bank back-pressure", errs_before);

        $display("tests run %0d, failed %0d, check errors %0d",
                 N_TESTS, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // run limit
    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not complete", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/dram_cfg_pkg.sv
src/dram_cmd_pkg.sv
src/sync_fifo.sv
src/write_queue.sv
src/request_scheduler.sv
src/bank_dispatch.sv
src/global_controller.sv
tests/tb_global_controller.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_global_controller
FILELIST  = tb.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
